// ==== common/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] rv_word_t;
  typedef logic [4:0]  rv_reg_t;

  // ************************************************************************
  // instruction word views
  // ************************************************************************

  typedef struct packed {
    logic [6:0] funct7;
    rv_reg_t    rs2;
    rv_reg_t    rs1;
    logic [2:0] funct3;
    rv_reg_t    rd;
    logic [6:0] opcode;
  } rv_inst_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    rv_reg_t     rs1;
    logic [2:0]  funct3;
    rv_reg_t     rd;
    logic [6:0]  opcode;
  } rv_inst_i_t;

  typedef struct packed {
    logic [19:0] imm20;
    rv_reg_t     rd;
    logic [6:0]  opcode;
  } rv_inst_u_t;

  typedef union packed {
    rv_inst_r_t r;
    rv_inst_i_t i;
    rv_inst_u_t u;
  } rv_inst_u;

  // major opcodes handled by this datapath
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // input payload, 64 bits
  typedef struct packed {
    rv_isa_pkg::rv_word_t pc;
    rv_isa_pkg::rv_inst_u inst;
  } inst_pkt_t;

  // control word carried from decode into execute
  typedef struct packed {
    logic                rd_w_v;
    logic                imm_v;
    logic                rs1_pc_sel;
    logic                zero_a_v;
    rv_isa_pkg::alu_op_t alu_op;
    logic                illegal_v;
  } cword_t;

  typedef struct packed {
    rv_isa_pkg::rv_word_t pc;
    rv_isa_pkg::rv_reg_t  rd;
    rv_isa_pkg::rv_word_t imm;
    rv_isa_pkg::rv_word_t rs1_data;
    rv_isa_pkg::rv_word_t rs2_data;
    cword_t               cword;
    logic                 fwd_rs1_v;
    logic                 fwd_rs2_v;
  } dec_pkt_t;

  // output record, one per instruction
  typedef struct packed {
    rv_isa_pkg::rv_word_t pc;
    rv_isa_pkg::rv_reg_t  rd;
    rv_isa_pkg::rv_word_t value;
    logic                 illegal_v;
  } result_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::rv_reg_t  rd;
    rv_isa_pkg::rv_word_t data;
  } wb_t;

endpackage

`default_nettype wire

// ==== pipeline/alu.sv ====
`default_nettype none

module alu (
  input  rv_isa_pkg::alu_op_t  op_i,
  input  rv_isa_pkg::rv_word_t a_i,
  input  rv_isa_pkg::rv_word_t b_i,
  output rv_isa_pkg::rv_word_t o_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rv_isa_pkg::ALU_ADD:    o_o = a_i + b_i;
      rv_isa_pkg::ALU_SUB:    o_o = a_i - b_i;
      rv_isa_pkg::ALU_SLL:    o_o = a_i << shamt;
      // set-less-than gives 0 or 1
      rv_isa_pkg::ALU_SLT:    o_o = {31'b0, $signed(a_i) < $signed(b_i)};
      rv_isa_pkg::ALU_SLTU:   o_o = {31'b0, a_i < b_i};
      rv_isa_pkg::ALU_XOR:    o_o = a_i ^ b_i;
      rv_isa_pkg::ALU_SRL:    o_o = a_i >> shamt;
      rv_isa_pkg::ALU_SRA:    o_o = $unsigned($signed(a_i) >>> shamt);
      rv_isa_pkg::ALU_OR:     o_o = a_i | b_i;
      rv_isa_pkg::ALU_AND:    o_o = a_i & b_i;
      rv_isa_pkg::ALU_PASS_B: o_o = b_i;
      default:                o_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== pipeline/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 reset_i,
  input  rv_isa_pkg::rv_reg_t  rs1_addr_i,
  input  rv_isa_pkg::rv_reg_t  rs2_addr_i,
  output rv_isa_pkg::rv_word_t rs1_data_o,
  output rv_isa_pkg::rv_word_t rs2_data_o,
  input  pipe_pkg::wb_t        wb_i
);

  rv_isa_pkg::rv_word_t regs [32];
  logic                 wr_v;

  // x0 never takes a write
  assign wr_v = wb_i.valid && (wb_i.rd != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int n = 0; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wr_v) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // write-through on a same-cycle read
  always_comb begin
    rs1_data_o = regs[rs1_addr_i];
    rs2_data_o = regs[rs2_addr_i];
    if (wr_v && (wb_i.rd == rs1_addr_i)) begin
      rs1_data_o = wb_i.data;
    end
    if (wr_v && (wb_i.rd == rs2_addr_i)) begin
      rs2_data_o = wb_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== pipeline/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 issue_valid_i,
  input  pipe_pkg::inst_pkt_t  issue_pkt_i,
  output rv_isa_pkg::rv_reg_t  rs1_addr_o,
  output rv_isa_pkg::rv_reg_t  rs2_addr_o,
  input  rv_isa_pkg::rv_word_t rs1_data_i,
  input  rv_isa_pkg::rv_word_t rs2_data_i,
  output logic                 dec_valid_o,
  output pipe_pkg::dec_pkt_t   dec_pkt_o
);

  rv_isa_pkg::rv_inst_u inst;
  pipe_pkg::cword_t     cword;
  rv_isa_pkg::rv_word_t imm;
  logic                 prev_w_v;

  function automatic rv_isa_pkg::alu_op_t f3_to_op(input logic [2:0] f3,
                                                   input logic sub_v,
                                                   input logic sra_v);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: return sub_v ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     return rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     return rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    return rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     return rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: return sra_v ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      return rv_isa_pkg::ALU_OR;
      default:                return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  assign inst       = issue_pkt_i.inst;
  assign rs1_addr_o = inst.r.rs1;
  assign rs2_addr_o = inst.r.rs2;

  always_comb begin
    cword        = '0;
    cword.alu_op = rv_isa_pkg::ALU_ADD;
    imm          = '0;
    case (inst.r.opcode)
      rv_isa_pkg::OP_REG: begin
        cword.rd_w_v = 1'b1;
        cword.alu_op = f3_to_op(inst.r.funct3, inst.r.funct7[5], inst.r.funct7[5]);
      end
      rv_isa_pkg::OP_IMM: begin
        // no SUBI, bit 30 only picks SRAI
        cword.rd_w_v = 1'b1;
        cword.imm_v  = 1'b1;
        cword.alu_op = f3_to_op(inst.i.funct3, 1'b0, inst.r.funct7[5]);
        imm          = {{20{inst.i.imm12[11]}}, inst.i.imm12};
      end
      rv_isa_pkg::OP_LUI: begin
        cword.rd_w_v   = 1'b1;
        cword.imm_v    = 1'b1;
        cword.zero_a_v = 1'b1;
        cword.alu_op   = rv_isa_pkg::ALU_PASS_B;
        imm            = {inst.u.imm20, 12'b0};
      end
      rv_isa_pkg::OP_AUIPC: begin
        cword.rd_w_v     = 1'b1;
        cword.imm_v      = 1'b1;
        cword.rs1_pc_sel = 1'b1;
        imm              = {inst.u.imm20, 12'b0};
      end
      default: begin
        // illegal results carry a zero value
        cword.illegal_v = 1'b1;
        cword.imm_v     = 1'b1;
        cword.zero_a_v  = 1'b1;
        cword.alu_op    = rv_isa_pkg::ALU_PASS_B;
      end
    endcase
  end

  // destination of the instruction now in execute
  assign prev_w_v = dec_valid_o && dec_pkt_o.cword.rd_w_v && (dec_pkt_o.rd != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    dec_pkt_o.pc        <= issue_pkt_i.pc;
    dec_pkt_o.rd        <= inst.r.rd;
    dec_pkt_o.imm       <= imm;
    dec_pkt_o.rs1_data  <= rs1_data_i;
    dec_pkt_o.rs2_data  <= rs2_data_i;
    dec_pkt_o.cword     <= cword;
    dec_pkt_o.fwd_rs1_v <= prev_w_v && (inst.r.rs1 == dec_pkt_o.rd);
    dec_pkt_o.fwd_rs2_v <= prev_w_v && (inst.r.rs2 == dec_pkt_o.rd);
  end

endmodule

`default_nettype wire

// ==== pipeline/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               dec_valid_i,
  input  pipe_pkg::dec_pkt_t dec_pkt_i,
  output logic               result_valid_o,
  output pipe_pkg::result_t  result_o,
  output pipe_pkg::wb_t      wb_o
);

  rv_isa_pkg::rv_word_t alu_a;
  rv_isa_pkg::rv_word_t alu_b;
  rv_isa_pkg::rv_word_t alu_result;
  rv_isa_pkg::rv_word_t execute_result;
  logic                 wb_v;

  assign execute_result = result_o.value;

  // ************************************************************************
  // operand select, pc and zero ahead of forwarding
  // ************************************************************************

  always_comb begin
    alu_a = dec_pkt_i.cword.rs1_pc_sel ? dec_pkt_i.pc :
            dec_pkt_i.cword.zero_a_v   ? '0 :
            dec_pkt_i.fwd_rs1_v        ? execute_result : dec_pkt_i.rs1_data;
    alu_b = dec_pkt_i.cword.imm_v      ? dec_pkt_i.imm :
            dec_pkt_i.fwd_rs2_v        ? execute_result : dec_pkt_i.rs2_data;
  end

  alu alu_i (
    .op_i (dec_pkt_i.cword.alu_op),
    .a_i  (alu_a),
    .b_i  (alu_b),
    .o_o  (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
      wb_v           <= 1'b0;
    end else begin
      result_valid_o <= dec_valid_i;
      wb_v           <= dec_valid_i && dec_pkt_i.cword.rd_w_v && !dec_pkt_i.cword.illegal_v;
    end
  end

  always_ff @(posedge clk) begin
    result_o.pc        <= dec_pkt_i.pc;
    result_o.rd        <= dec_pkt_i.rd;
    result_o.value     <= alu_result;
    result_o.illegal_v <= dec_pkt_i.cword.illegal_v;
  end

  assign wb_o.valid = wb_v;
  assign wb_o.rd    = result_o.rd;
  assign wb_o.data  = result_o.value;

endmodule

`default_nettype wire

// ==== design/issue_queue.sv ====
`default_nettype none

module issue_queue #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int RESULT_CREDITS = 2
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                inst_valid_i,
  input  pipe_pkg::inst_pkt_t inst_i,
  output logic                inst_credit_o,
  input  logic                result_credit_i,
  output logic                issue_valid_o,
  output pipe_pkg::inst_pkt_t issue_pkt_o
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(RESULT_CREDITS + 1);

  pipe_pkg::inst_pkt_t mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic [CRD_W-1:0]    result_credits;
  logic                issue_fire;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // issue needs an entry and room at the consumer
  assign issue_fire    = (count != '0) && (result_credits != '0);
  assign issue_valid_o = issue_fire;
  assign issue_pkt_o   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (inst_valid_i) begin
      mem[wr_ptr] <= inst_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      result_credits <= CRD_W'(RESULT_CREDITS);
      inst_credit_o  <= 1'b0;
    end else begin
      if (inst_valid_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (issue_fire) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({inst_valid_i, issue_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // spend on issue, refill on consumer pulse
      case ({issue_fire, result_credit_i})
        2'b10:   result_credits <= result_credits - 1'b1;
        2'b01:   result_credits <= result_credits + 1'b1;
        default: result_credits <= result_credits;
      endcase
      inst_credit_o <= issue_fire;
    end
  end

endmodule

`default_nettype wire

// ==== design/int_pipe.sv ====
`default_nettype none

module int_pipe #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int RESULT_CREDITS = 2
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                inst_valid_i,
  input  pipe_pkg::inst_pkt_t inst_i,
  output logic                inst_credit_o,
  output logic                result_valid_o,
  output pipe_pkg::result_t   result_o,
  input  logic                result_credit_i
);

  logic                 issue_valid;
  pipe_pkg::inst_pkt_t  issue_pkt;
  rv_isa_pkg::rv_reg_t  rs1_addr;
  rv_isa_pkg::rv_reg_t  rs2_addr;
  rv_isa_pkg::rv_word_t rs1_data;
  rv_isa_pkg::rv_word_t rs2_data;
  logic                 dec_valid;
  pipe_pkg::dec_pkt_t   dec_pkt;
  pipe_pkg::wb_t        wb;

  issue_queue #(
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .RESULT_CREDITS (RESULT_CREDITS)
  ) issue_queue_i (
    .clk             (clk),
    .reset_i         (reset_i),
    .inst_valid_i    (inst_valid_i),
    .inst_i          (inst_i),
    .inst_credit_o   (inst_credit_o),
    .result_credit_i (result_credit_i),
    .issue_valid_o   (issue_valid),
    .issue_pkt_o     (issue_pkt)
  );

  decode_stage decode_stage_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid),
    .issue_pkt_i   (issue_pkt),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .dec_valid_o   (dec_valid),
    .dec_pkt_o     (dec_pkt)
  );

  reg_file reg_file_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb)
  );

  execute_stage execute_stage_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .dec_valid_i    (dec_valid),
    .dec_pkt_i      (dec_pkt),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .wb_o           (wb)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_int_pipe.sv ====
`default_nettype none

module tb_int_pipe;

  localparam int QUEUE_DEPTH    = 4;
  localparam int RESULT_CREDITS = 2;
  localparam int CLK_PERIOD     = 40;
  localparam int NUM_INSTS      = 600;
  localparam int TIMEOUT_CYCLES = 60 * NUM_INSTS;
  localparam int LONE_LATENCY   = 3;

  logic                clk;
  logic                reset_i;
  logic                inst_valid_i;
  pipe_pkg::inst_pkt_t inst_i;
  logic                inst_credit_o;
  logic                result_valid_o;
  pipe_pkg::result_t   result_o;
  logic                result_credit_i;

  rv_isa_pkg::rv_word_t model_regs [32];
  pipe_pkg::result_t    exp_q [$];
  int                   accept_q [$];
  bit                   lone_q [$];
  logic [31:0]          lfsr;
  rv_isa_pkg::rv_word_t next_pc;
  int                   cycle;
  int                   sent;
  int                   seen;
  int                   credit_pulses;
  int                   inst_credits;
  int                   occupancy;
  int                   hold_cycles;
  int                   lone_checked;

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) tb_clock_gen_i (.clk_o(clk));

  int_pipe #(
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .RESULT_CREDITS (RESULT_CREDITS)
  ) int_pipe_i (
    .clk             (clk),
    .reset_i         (reset_i),
    .inst_valid_i    (inst_valid_i),
    .inst_i          (inst_i),
    .inst_credit_o   (inst_credit_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .result_credit_i (result_credit_i)
  );

  // ************************************************************************
  // random source and instruction generation
  // ************************************************************************

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // mostly x0..x3 so that dependences are frequent
  function automatic rv_isa_pkg::rv_reg_t pick_reg();
    if (rand_bits(2) != 32'd0) begin
      return rv_isa_pkg::rv_reg_t'(rand_bits(2));
    end
    return rv_isa_pkg::rv_reg_t'(rand_bits(5));
  endfunction

  function automatic rv_isa_pkg::rv_inst_u gen_inst();
    rv_isa_pkg::rv_inst_u inst;
    logic [3:0]           kind;
    logic [2:0]           f3;
    logic                 alt;
    logic [6:0]           opc;
    inst = '0;
    kind = 4'(rand_bits(4));
    f3   = 3'(rand_bits(3));
    alt  = (rand_bits(1) != 32'd0);
    if (kind <= 4'd5 || kind == 4'd15) begin
      inst.r.opcode = rv_isa_pkg::OP_REG;
      inst.r.funct3 = f3;
      inst.r.rd     = pick_reg();
      inst.r.rs1    = pick_reg();
      inst.r.rs2    = pick_reg();
      if (alt && (f3 == 3'b000 || f3 == 3'b101)) begin
        inst.r.funct7 = 7'b0100000;
      end
    end else if (kind <= 4'd10) begin
      inst.i.opcode = rv_isa_pkg::OP_IMM;
      inst.i.funct3 = f3;
      inst.i.rd     = pick_reg();
      inst.i.rs1    = pick_reg();
      inst.i.imm12  = 12'(rand_bits(12));
      if (f3 == 3'b001) begin
        inst.i.imm12 = {7'b0, 5'(rand_bits(5))};
      end else if (f3 == 3'b101) begin
        inst.i.imm12 = {1'b0, alt, 5'b0, 5'(rand_bits(5))};
      end
    end else if (kind <= 4'd13) begin
      inst.u.opcode = (kind == 4'd13) ? rv_isa_pkg::OP_AUIPC : rv_isa_pkg::OP_LUI;
      inst.u.rd     = pick_reg();
      inst.u.imm20  = 20'(rand_bits(20));
    end else begin
      inst = rand_bits(32);
      opc  = inst.r.opcode;
      if (opc == rv_isa_pkg::OP_REG || opc == rv_isa_pkg::OP_IMM ||
          opc == rv_isa_pkg::OP_LUI || opc == rv_isa_pkg::OP_AUIPC) begin
        // remap onto a branch opcode, which this datapath leaves out
        inst.r.opcode = 7'b1100011;
      end
    end
    return inst;
  endfunction

  // ************************************************************************
  // reference model from the RV32I rules
  // ************************************************************************

  function automatic rv_isa_pkg::rv_word_t ref_op(input logic [2:0] f3,
                                                  input logic alt_v,
                                                  input rv_isa_pkg::rv_word_t a,
                                                  input rv_isa_pkg::rv_word_t b);
    logic [4:0]           sh;
    rv_isa_pkg::rv_word_t fill;
    sh   = b[4:0];
    // sign bits that an arithmetic shift brings in from the top
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
    case (f3)
      3'b000:  return alt_v ? a - b : a + b;
      3'b001:  return a << sh;
      // when the signs differ the negative operand is the smaller one
      3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt_v ? ((a >> sh) | fill) : (a >> sh);
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic pipe_pkg::result_t model_exec(input pipe_pkg::inst_pkt_t pkt);
    pipe_pkg::result_t    res;
    rv_isa_pkg::rv_inst_u inst;
    rv_isa_pkg::rv_word_t a;
    rv_isa_pkg::rv_word_t b;
    rv_isa_pkg::rv_word_t imm_i;
    inst          = pkt.inst;
    a             = model_regs[inst.r.rs1];
    b             = model_regs[inst.r.rs2];
    imm_i         = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    res.pc        = pkt.pc;
    res.rd        = inst.r.rd;
    res.value     = '0;
    res.illegal_v = 1'b0;
    case (inst.r.opcode)
      rv_isa_pkg::OP_REG:   res.value = ref_op(inst.r.funct3, inst.r.funct7[5], a, b);
      rv_isa_pkg::OP_IMM:   res.value = ref_op(inst.i.funct3,
                                               (inst.i.funct3 == 3'b101) && inst.r.funct7[5],
                                               a, imm_i);
      rv_isa_pkg::OP_LUI:   res.value = {inst.u.imm20, 12'b0};
      rv_isa_pkg::OP_AUIPC: res.value = pkt.pc + {inst.u.imm20, 12'b0};
      default:              res.illegal_v = 1'b1;
    endcase
    if (!res.illegal_v && res.rd != '0) begin
      model_regs[res.rd] = res.value;
    end
    return res;
  endfunction

  // ************************************************************************
  // checks
  // ************************************************************************

  task automatic end_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic check_result(input pipe_pkg::result_t got, input pipe_pkg::result_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t: result pc=%h rd=%0d value=%h illegal=%b",
               $time, got.pc, got.rd, got.value, got.illegal_v);
      $display("MISMATCH t=%0t: expected pc=%h rd=%0d value=%h illegal=%b",
               $time, exp.pc, exp.rd, exp.value, exp.illegal_v);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic observe_outputs();
    pipe_pkg::result_t exp;
    int                acc;
    bit                lone;
    if (inst_credit_o) begin
      credit_pulses++;
      inst_credits++;
      if (credit_pulses > sent || inst_credits > QUEUE_DEPTH) begin
        report_error("inst_credit_o returned more credits than instructions were sent");
      end
    end
    if (result_valid_o) begin
      if (exp_q.size() == 0) begin
        report_error("result_valid_o rose with no instruction outstanding");
      end
      exp  = exp_q.pop_front();
      acc  = accept_q.pop_front();
      lone = lone_q.pop_front();
      check_result(result_o, exp);
      seen++;
      occupancy++;
      if (occupancy > RESULT_CREDITS) begin
        report_error("a result arrived while the result buffer had no free slot");
      end
      if (lone) begin
        check_count("latency of a lone instruction", cycle - acc, LONE_LATENCY);
        lone_checked++;
      end
    end
  endtask

  // ************************************************************************
  // stimulus
  // ************************************************************************

  task automatic drive_result_credit();
    result_credit_i = 1'b0;
    if (hold_cycles > 0) begin
      hold_cycles--;
    end else if (rand_bits(5) == 32'd0) begin
      // consumer stalls for a while
      hold_cycles = 8 + int'(rand_bits(4));
    end else if (occupancy > 0 && rand_bits(1) != 32'd0) begin
      result_credit_i = 1'b1;
      occupancy--;
    end
  endtask

  task automatic drive_instruction();
    pipe_pkg::inst_pkt_t pkt;
    inst_valid_i = 1'b0;
    if (sent < NUM_INSTS && inst_credits > 0 && rand_bits(1) != 32'd0) begin
      pkt.pc   = next_pc;
      pkt.inst = gen_inst();
      // idle pipeline and a full result counter at the sampling edge
      lone_q.push_back(sent == seen && occupancy == 0);
      accept_q.push_back(cycle);
      exp_q.push_back(model_exec(pkt));
      inst_i       = pkt;
      inst_valid_i = 1'b1;
      inst_credits--;
      sent++;
      next_pc += 32'd4;
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("ERROR t=%0t: timeout, the pipeline stopped delivering results", $time);
    end_with_failure();
  end

  initial begin : stimulus
    reset_i         = 1'b1;
    inst_valid_i    = 1'b0;
    inst_i          = '0;
    result_credit_i = 1'b0;
    lfsr            = 32'h0332c086;
    next_pc         = 32'h0000_1000;
    cycle           = 0;
    sent            = 0;
    seen            = 0;
    credit_pulses   = 0;
    inst_credits    = QUEUE_DEPTH;
    occupancy       = 0;
    hold_cycles     = 0;
    lone_checked    = 0;
    for (int n = 0; n < 32; n++) begin
      model_regs[n] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    while (sent < NUM_INSTS || exp_q.size() != 0 || occupancy != 0) begin
      @(posedge clk);
      #1;
      cycle++;
      observe_outputs();
      drive_result_credit();
      drive_instruction();
    end
    @(posedge clk);
    #1;
    result_credit_i = 1'b0;
    inst_valid_i    = 1'b0;
    check_count("inst_credit_o pulses", credit_pulses, sent);
    if (lone_checked == 0) begin
      report_error("no lone instruction was seen, latency went unchecked");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/rv_isa_pkg.sv
common/pipe_pkg.sv
pipeline/alu.sv
pipeline/reg_file.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
design/issue_queue.sv
design/int_pipe.sv
testbench/tb_clock_gen.sv
testbench/tb_int_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_int_pipe
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
